// ==== vlog.f ====
verilog/mmio_pkg.sv
verilog/mmio_write_capture.sv
verilog/mmio_read_control.sv
verilog/feature_header_block.sv
verilog/csr_read_mux.sv
verilog/mmio_csr_top.sv
sim/tb_mmio_csr.sv

// ==== Makefile ====
TOP = tb_mmio_csr

.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/1ns -f vlog.f --top-module $(TOP) \
		--Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP)

clean:
	rm -rf obj_dir

// ==== sim/tb_mmio_csr.sv ====
// ==================================================
// Testbench for the MMIO CSR responder
// Drives reads and writes with random stalls and compares every
// response with a reference model of the read map
// ==================================================
`timescale 1ns/1ns
`default_nettype none

module tb_mmio_csr;

    import mmio_pkg::*;

    logic       clk = 1'b0;
    logic       reset_n;
    logic       aw_valid;
    mmio_aw_t   aw;
    logic       aw_ready;
    logic       w_valid;
    mmio_w_t    w;
    logic       w_ready;
    logic       b_valid;
    mmio_b_t    b;
    logic       b_ready;
    logic       ar_valid;
    mmio_ar_t   ar;
    logic       ar_ready;
    logic       r_valid;
    mmio_r_t    r;
    logic       r_ready;

    integer     seed = 32'h1a7cf001;
    int         cycles = 0;

    // Last completed write as the host sees it
    mmio_aw_t   model_aw;
    mmio_w_t    model_w;

    // Responses the DUT still owes, oldest first
    mmio_r_t    exp_r_q[$];
    mmio_b_t    exp_b_q[$];

    always #20 clk = ~clk;

    mmio_csr_top DUT (
        .clk      (clk),
        .reset_n  (reset_n),
        .aw_valid (aw_valid),
        .aw       (aw),
        .aw_ready (aw_ready),
        .w_valid  (w_valid),
        .w        (w),
        .w_ready  (w_ready),
        .b_valid  (b_valid),
        .b        (b),
        .b_ready  (b_ready),
        .ar_valid (ar_valid),
        .ar       (ar),
        .ar_ready (ar_ready),
        .r_valid  (r_valid),
        .r        (r),
        .r_ready  (r_ready)
    );

    // ==================================================
    // Failure reporting and compare tasks
    // ==================================================
    task automatic end_run_failed;
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic report_problem(input string why);
        $display("[ERROR] %0t ns: %s", $time, why);
        end_run_failed();
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("[ERROR] %0t ns: %s got %b expected %b", $time, name, got, exp);
            end_run_failed();
        end
    endtask

    task automatic check_read(input string name, input mmio_r_t got, input mmio_r_t exp);
        if (got !== exp)
        begin
            $display("[ERROR] %0t ns: %s got %h expected %h", $time, name, got, exp);
            end_run_failed();
        end
    endtask

    task automatic check_write_resp(input string name, input mmio_b_t got, input mmio_b_t exp);
        if (got !== exp)
        begin
            $display("[ERROR] %0t ns: %s got %h expected %h", $time, name, got, exp);
            end_run_failed();
        end
    endtask

    // ==================================================
    // Reference model of the read map
    // ==================================================
    function automatic mmio_r_t expected_read(input mmio_ar_t req, input mmio_aw_t m_aw,
                                              input mmio_w_t m_w);
        mmio_r_t    e;
        csr_idx_t   idx;
        logic [2:0] lane;
        e = '0;
        e.id = req.id;
        e.user = req.user;
        idx = req.addr[14:3];
        lane = m_aw.addr[5:3];
        // Upper eight index bits pick a group of sixteen registers
        case (idx[11:4])
            8'h00:
            begin
                e.data.lanes[0][63:60] = 4'h1;
                e.data.lanes[0][40] = 1'b1;
                e.data.lanes[1] = AFU_ID[63:0];
                e.data.lanes[2] = AFU_ID[127:64];
                e.data.lanes[7] = {req.addr, req.addr};
            end
            8'h01:
            begin
                // Frequency in bits 31:16, bus width in 15:14, interface kind in 3:0
                if (idx[3:0] == 4'h0)
                begin
                    e.data.lanes[0][31:16] = PCLK_FREQ_MHZ;
                    e.data.lanes[0][15:14] = BUS_WIDTH_CODE;
                    e.data.lanes[0][3:0] = IF_KIND_CODE;
                end
            end
            8'h02:
            begin
                if (idx[3:0] == 4'h0)
                    e.data = m_w.data;
            end
            8'h03:
            begin
                e.data.lanes[0] = {32'h0, m_aw.addr};
                e.data.lanes[1] = {56'h0, m_w.strb[int'(lane) * 8 +: 8]};
            end
            8'h04:
            begin
                e.data = m_w.data;
            end
            8'h05:
            begin
                e.data.lanes[0] = {32'h0, m_aw.addr};
                e.data.lanes[1] = m_w.strb;
            end
            default:
            begin
                e.data = '0;
            end
        endcase
        return e;
    endfunction

    // ==================================================
    // Random stimulus helpers
    // ==================================================
    function automatic logic [31:0] next_random();
        return $random(seed);
    endfunction

    function automatic int rand_below(input int limit);
        logic [31:0] v;
        v = next_random();
        return int'(v % limit);
    endfunction

    // Random upper and lowest address bits around the index, random id and user
    function automatic mmio_ar_t make_read(input csr_idx_t idx);
        mmio_ar_t    req;
        logic [31:0] v;
        logic [31:0] s;
        v = next_random();
        s = next_random();
        req.addr = {v[31:15], idx, v[2:0]};
        req.id = s[3:0];
        req.user = s[4:4];
        return req;
    endfunction

    // Any index outside groups 0x00 to 0x05
    function automatic csr_idx_t unmapped_idx();
        logic [31:0] v;
        csr_idx_t    idx;
        v = next_random();
        idx = v[11:0];
        if (idx[11:4] <= 8'h05)
            idx[11] = 1'b1;
        return idx;
    endfunction

    function automatic mmio_w_t make_write_data();
        mmio_w_t d;
        for (int i = 0; i < 16; i++)
            d.data.flat[32 * i +: 32] = next_random();
        d.strb = {next_random(), next_random()};
        return d;
    endfunction

    // ==================================================
    // Bus transactions
    // ==================================================
    // Starts and ends just after a rising edge and checks latency and stall behavior
    task automatic run_read(input mmio_ar_t req, input logic stall);
        mmio_r_t exp_rd;
        int      n;
        n = rand_below(6) + 1;
        exp_rd = expected_read(req, model_aw, model_w);
        ar <= req;
        ar_valid <= 1'b1;
        r_ready <= !stall;
        exp_r_q.push_back(exp_rd);
        @(posedge clk);
        while (!ar_ready)
            @(posedge clk);
        ar_valid <= 1'b0;
        // Two pipeline stages follow the accepting edge
        repeat (2)
        begin
            @(posedge clk);
            check_flag("r_valid", r_valid, 1'b0);
            check_flag("ar_ready", ar_ready, 1'b0);
        end
        @(posedge clk);
        check_flag("r_valid", r_valid, 1'b1);
        check_flag("ar_ready", ar_ready, 1'b0);
        if (stall)
        begin
            check_read("r", r, exp_rd);
            repeat (n)
            begin
                @(posedge clk);
                check_flag("r_valid", r_valid, 1'b1);
                check_flag("ar_ready", ar_ready, 1'b0);
                check_read("r", r, exp_rd);
            end
            r_ready <= 1'b1;
            @(posedge clk);
        end
        // Cycle after the response handshake
        @(posedge clk);
        check_flag("ar_ready", ar_ready, 1'b1);
    endtask

    // Order 0 offers both channels together, 1 the address first, 2 the data first
    task automatic run_write(input mmio_aw_t a, input mmio_w_t d, input int order,
                             input logic stall);
        mmio_b_t eb;
        logic    aw_done;
        logic    w_done;
        int      n;
        n = rand_below(6) + 1;
        aw_done = 1'b0;
        w_done = 1'b0;
        eb.id = a.id;
        eb.user = a.user;
        exp_b_q.push_back(eb);
        b_ready <= !stall;
        if (order != 2)
        begin
            aw <= a;
            aw_valid <= 1'b1;
        end
        if (order != 1)
        begin
            w <= d;
            w_valid <= 1'b1;
        end
        while (!(aw_done && w_done))
        begin
            @(posedge clk);
            if (aw_valid && aw_ready)
            begin
                aw_done = 1'b1;
                aw_valid <= 1'b0;
            end
            if (w_valid && w_ready)
            begin
                w_done = 1'b1;
                w_valid <= 1'b0;
            end
            // The second channel goes out once the first is taken
            if (aw_done && !w_done && !w_valid)
            begin
                w <= d;
                w_valid <= 1'b1;
            end
            if (w_done && !aw_done && !aw_valid)
            begin
                aw <= a;
                aw_valid <= 1'b1;
            end
        end
        if (stall)
        begin
            repeat (n)
            begin
                @(posedge clk);
                check_flag("aw_ready", aw_ready, 1'b0);
                check_flag("w_ready", w_ready, 1'b0);
                check_flag("b_valid", b_valid, 1'b0);
            end
            b_ready <= 1'b1;
        end
        @(posedge clk);
        while (!b_valid)
            @(posedge clk);
        model_aw = a;
        model_w = d;
    endtask

    // ==================================================
    // Response compare and timeout
    // ==================================================
    always @(posedge clk)
    begin
        if (r_valid && r_ready)
        begin
            if (exp_r_q.size() == 0)
                report_problem("read response arrived with no read pending");
            else
                check_read("r", r, exp_r_q.pop_front());
        end
        if (b_valid && b_ready)
        begin
            if (exp_b_q.size() == 0)
                report_problem("write response arrived with no write pending");
            else
                check_write_resp("b", b, exp_b_q.pop_front());
        end
    end

    // About 200 transactions of at most 12 cycles each, with margin
    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles >= 4000)
            report_problem("timeout, the DUT stopped answering");
    end

    // ==================================================
    // Test sequence
    // ==================================================
    initial
    begin
        mmio_aw_t    a;
        logic [31:0] v;
        model_aw = '0;
        model_w = '0;
        reset_n <= 1'b0;
        aw_valid <= 1'b0;
        aw <= '0;
        w_valid <= 1'b0;
        w <= '0;
        b_ready <= 1'b0;
        ar_valid <= 1'b0;
        ar <= '0;
        r_ready <= 1'b0;
        repeat (5)
            @(posedge clk);
        reset_n <= 1'b1;
        @(posedge clk);
        check_flag("ar_ready", ar_ready, 1'b1);
        check_flag("aw_ready", aw_ready, 1'b1);
        check_flag("w_ready", w_ready, 1'b1);
        check_flag("b_valid", b_valid, 1'b0);
        check_flag("r_valid", r_valid, 1'b0);

        // Stored write state is zero before the first write
        run_read(make_read(CSR_IDX_WR64_DATA), 1'b0);
        run_read(make_read(CSR_IDX_WR64_INFO | 12'h5), 1'b1);
        run_read(make_read(CSR_IDX_WR512_DATA | 12'h7), 1'b0);
        run_read(make_read(CSR_IDX_WR512_INFO | 12'ha), 1'b1);

        for (int k = 0; k < 16; k++)
            run_read(make_read(csr_idx_t'(k)), rand_below(2) == 1);
        run_read(make_read(CSR_IDX_STATUS), 1'b0);

        // Write round trips with every channel order and response stalls
        for (int k = 0; k < 30; k++)
        begin
            v = next_random();
            a.addr = next_random();
            a.id = v[3:0];
            a.user = v[4:4];
            run_write(a, make_write_data(), rand_below(3), rand_below(2) == 1);
            run_read(make_read(CSR_IDX_WR64_DATA), rand_below(2) == 1);
            run_read(make_read(CSR_IDX_WR64_INFO | csr_idx_t'(rand_below(16))),
                     rand_below(2) == 1);
            run_read(make_read(CSR_IDX_WR512_DATA | csr_idx_t'(rand_below(16))),
                     rand_below(2) == 1);
            run_read(make_read(CSR_IDX_WR512_INFO | csr_idx_t'(rand_below(16))),
                     rand_below(2) == 1);
        end

        // Holes inside mapped groups and indices past the map
        run_read(make_read(12'h011), 1'b0);
        run_read(make_read(12'h021), 1'b1);
        run_read(make_read(12'h02f), 1'b0);
        run_read(make_read(12'h060), 1'b0);
        for (int k = 0; k < 10; k++)
            run_read(make_read(unmapped_idx()), rand_below(2) == 1);
        run_read(make_read(CSR_IDX_STATUS), 1'b1);

        if (exp_r_q.size() != 0 || exp_b_q.size() != 0)
        begin
            report_problem("some responses never arrived");
        end
        else
        begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/mmio_csr_top.sv ====
// ==================================================
// Top level of the MMIO CSR responder
// Joins the read control with the write capture and read datapath
// ==================================================
`timescale 1ns/1ns
`default_nettype none

module mmio_csr_top
(
    input  wire logic                clk,
    input  wire logic                reset_n,
    input  wire logic                aw_valid,
    input  wire mmio_pkg::mmio_aw_t   aw,
    output logic                     aw_ready,
    input  wire logic                w_valid,
    input  wire mmio_pkg::mmio_w_t    w,
    output logic                     w_ready,
    output logic                     b_valid,
    output mmio_pkg::mmio_b_t        b,
    input  wire logic                b_ready,
    input  wire logic                ar_valid,
    input  wire mmio_pkg::mmio_ar_t   ar,
    output logic                     ar_ready,
    output logic                     r_valid,
    output mmio_pkg::mmio_r_t        r,
    input  wire logic                r_ready
);

    import mmio_pkg::*;

    // Held read request and its register index
    mmio_ar_t   rd_req;
    csr_idx_t   rd_idx;
    // Header word and last completed write state
    mmio_data_u hdr;
    mmio_aw_t   wr_aw;
    mmio_w_t    wr_w;

    mmio_read_control u_read_control (
        .clk      (clk),
        .reset_n  (reset_n),
        .ar_valid (ar_valid),
        .ar       (ar),
        .ar_ready (ar_ready),
        .rd_req   (rd_req),
        .rd_idx   (rd_idx),
        .r_valid  (r_valid),
        .r_ready  (r_ready)
    );

    mmio_write_capture u_write_capture (
        .clk      (clk),
        .reset_n  (reset_n),
        .aw_valid (aw_valid),
        .aw       (aw),
        .aw_ready (aw_ready),
        .w_valid  (w_valid),
        .w        (w),
        .w_ready  (w_ready),
        .b_valid  (b_valid),
        .b        (b),
        .b_ready  (b_ready),
        .wr_aw    (wr_aw),
        .wr_w     (wr_w)
    );

    feature_header_block u_feature_header (
        .clk    (clk),
        .rd_req (rd_req),
        .hdr    (hdr)
    );

    csr_read_mux u_read_mux (
        .clk    (clk),
        .rd_idx (rd_idx),
        .rd_req (rd_req),
        .hdr    (hdr),
        .wr_aw  (wr_aw),
        .wr_w   (wr_w),
        .r      (r)
    );

endmodule

`default_nettype wire

// ==== verilog/csr_read_mux.sv ====
// ==================================================
// Read data selection for the CSR responder
// Decodes the register index and registers the read response
// ==================================================
`timescale 1ns/1ns
`default_nettype none

module csr_read_mux
(
    input  wire logic                clk,
    input  wire mmio_pkg::csr_idx_t   rd_idx,
    input  wire mmio_pkg::mmio_ar_t   rd_req,
    input  wire mmio_pkg::mmio_data_u hdr,
    input  wire mmio_pkg::mmio_aw_t   wr_aw,
    input  wire mmio_pkg::mmio_w_t    wr_w,
    output mmio_pkg::mmio_r_t        r
);

    import mmio_pkg::*;

    logic [63:0] status_word;
    logic [7:0]  strb_byte;
    mmio_data_u  sel_data;

    // True when the index lies in the sixteen-entry group starting at base
    function automatic logic in_group(input csr_idx_t idx, input csr_idx_t base);
        return idx[11:4] == base[11:4];
    endfunction

    // Status word with clock frequency, bus width and interface kind
    assign status_word = {32'h0, PCLK_FREQ_MHZ, BUS_WIDTH_CODE, 10'h0, IF_KIND_CODE};

    // Strobes of the 64-bit lane addressed by the last write
    assign strb_byte = wr_w.strb[{wr_aw.addr[5:3], 3'b000} +: 8];

    // ==================================================
    // Index decode
    // ==================================================
    always_comb
    begin
        sel_data = '0;

        if (in_group(rd_idx, CSR_IDX_HDR_BASE))
        begin
            sel_data = hdr;
        end
        else if (rd_idx == CSR_IDX_STATUS)
        begin
            sel_data.lanes[0] = status_word;
        end
        else if (rd_idx == CSR_IDX_WR64_DATA || in_group(rd_idx, CSR_IDX_WR512_DATA))
        begin
            // Same stored word whether read as one 64-bit register or eight
            sel_data = wr_w.data;
        end
        else if (in_group(rd_idx, CSR_IDX_WR64_INFO))
        begin
            sel_data.lanes[0] = {32'h0, wr_aw.addr};
            sel_data.lanes[1] = {56'h0, strb_byte};
        end
        else if (in_group(rd_idx, CSR_IDX_WR512_INFO))
        begin
            sel_data.lanes[0] = {32'h0, wr_aw.addr};
            sel_data.lanes[1] = wr_w.strb;
        end
    end

    // The held request is steady, so r stays steady while the host stalls
    always_ff @(posedge clk)
    begin
        r.id   <= rd_req.id;
        r.user <= rd_req.user;
        r.data <= sel_data;
    end

endmodule

`default_nettype wire

// ==== verilog/feature_header_block.sv ====
// ==================================================
// Device feature header word for the CSR responder
// Rebuilt every cycle so it is ready by the second read stage
// ==================================================
`timescale 1ns/1ns
`default_nettype none

module feature_header_block
(
    input  wire logic              clk,
    input  wire mmio_pkg::mmio_ar_t rd_req,
    output mmio_pkg::mmio_data_u   hdr
);

    import mmio_pkg::*;

    mmio_data_u hdr_d;

    always_comb
    begin
        hdr_d = '0;

        // This unit is the only entry of the feature list
        hdr_d.lanes[0][63:60] = DFH_TYPE_AFU;
        // End of list flag
        hdr_d.lanes[0][40] = 1'b1;

        // Unit identifier, low half first
        hdr_d.lanes[1] = AFU_ID[63:0];
        hdr_d.lanes[2] = AFU_ID[127:64];

        // Byte address of the read in both halves, so a 32-bit reader sees it in either
        hdr_d.lanes[7] = {rd_req.addr, rd_req.addr};
    end

    always_ff @(posedge clk)
    begin
        hdr <= hdr_d;
    end

endmodule

`default_nettype wire

// ==== verilog/mmio_read_control.sv ====
// ==================================================
// Read control of the CSR responder
// Holds one read, sequences the two-cycle answer and retires on handshake
// ==================================================
`timescale 1ns/1ns
`default_nettype none

module mmio_read_control
(
    input  wire logic               clk,
    input  wire logic               reset_n,
    input  wire logic               ar_valid,
    input  wire mmio_pkg::mmio_ar_t  ar,
    output logic                    ar_ready,
    output mmio_pkg::mmio_ar_t      rd_req,
    output mmio_pkg::csr_idx_t      rd_idx,
    output logic                    r_valid,
    input  wire logic               r_ready
);

    import mmio_pkg::*;

    // A request is held from acceptance until its response is taken
    logic ar_held;
    // Request stage, one cycle behind the held flag
    logic req_q;
    logic rd_accept;
    logic rd_retire;

    assign ar_ready  = !ar_held;
    assign rd_accept = ar_valid && ar_ready;
    assign rd_retire = r_valid && r_ready;

    // ==================================================
    // Control sequence
    // ==================================================
    always_ff @(posedge clk)
    begin
        if (!reset_n || rd_retire)
        begin
            ar_held <= 1'b0;
            req_q   <= 1'b0;
            r_valid <= 1'b0;
        end
        else
        begin
            if (rd_accept)
            begin
                ar_held <= 1'b1;
            end
            // Stage one registers the index, stage two registers the data
            req_q   <= ar_held;
            r_valid <= req_q;
        end
    end

    // ==================================================
    // Request payload
    // ==================================================
    always_ff @(posedge clk)
    begin
        if (rd_accept)
        begin
            rd_req <= ar;
        end
        // Byte address becomes a 64-bit register index
        rd_idx <= rd_req.addr[3 +: $bits(csr_idx_t)];
    end

endmodule

`default_nettype wire

// ==== verilog/mmio_write_capture.sv ====
// ==================================================
// Write path of the CSR responder
// Captures address and data separately and answers once both are held
// ==================================================
`timescale 1ns/1ns
`default_nettype none

module mmio_write_capture
(
    input  wire logic              clk,
    input  wire logic              reset_n,
    input  wire logic              aw_valid,
    input  wire mmio_pkg::mmio_aw_t aw,
    output logic                   aw_ready,
    input  wire logic              w_valid,
    input  wire mmio_pkg::mmio_w_t  w,
    output logic                   w_ready,
    output logic                   b_valid,
    output mmio_pkg::mmio_b_t      b,
    input  wire logic              b_ready,
    output mmio_pkg::mmio_aw_t     wr_aw,
    output mmio_pkg::mmio_w_t      wr_w
);

    // Flags telling whether each channel has a payload waiting
    logic aw_held;
    logic w_held;
    logic wr_done;

    // A write retires once both halves are present and the host can take the response
    assign wr_done = aw_held && w_held && b_ready;

    // Each channel stalls while its own payload is still waiting
    assign aw_ready = !aw_held;
    assign w_ready  = !w_held;

    // Response follows the id and user of the held address
    assign b_valid = wr_done;
    assign b.id    = wr_aw.id;
    assign b.user  = wr_aw.user;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            aw_held <= 1'b0;
            w_held  <= 1'b0;
            // Stored write state reads back as zero until the first write
            wr_aw   <= '0;
            wr_w    <= '0;
        end
        else
        begin
            if (aw_valid && aw_ready)
            begin
                aw_held <= 1'b1;
                wr_aw   <= aw;
            end
            if (w_valid && w_ready)
            begin
                w_held <= 1'b1;
                wr_w   <= w;
            end
            // Both ready signals are low here, so clearing cannot race a capture
            if (wr_done)
            begin
                aw_held <= 1'b0;
                w_held  <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/mmio_pkg.sv ====
// ==================================================
// Shared types and constants for the MMIO CSR responder
// Channel payload structs, the 512-bit data union and the read map
// ==================================================
`default_nettype none

package mmio_pkg;

    // Basic field types of the MMIO bus
    typedef logic [31:0] mmio_addr_t;
    typedef logic [3:0]  mmio_id_t;
    typedef logic [0:0]  mmio_user_t;

    // Index of a 64-bit register, taken from byte address bits 14:3
    typedef logic [11:0] csr_idx_t;

    // One bus data word, seen whole or as eight 64-bit lanes
    typedef union packed {
        logic [511:0]     flat;
        logic [7:0][63:0] lanes;
    } mmio_data_u;

    // Write and read address channels carry the same payload
    typedef struct packed {
        mmio_addr_t addr;
        mmio_id_t   id;
        mmio_user_t user;
    } mmio_aw_t;

    typedef mmio_aw_t mmio_ar_t;

    // Write data with one strobe per byte lane
    typedef struct packed {
        mmio_data_u  data;
        logic [63:0] strb;
    } mmio_w_t;

    typedef struct packed {
        mmio_id_t   id;
        mmio_user_t user;
    } mmio_b_t;

    typedef struct packed {
        mmio_id_t   id;
        mmio_user_t user;
        mmio_data_u data;
    } mmio_r_t;

    // ==================================================
    // Device identity and status constants
    // ==================================================
    localparam logic [127:0] AFU_ID = 128'h5f2c_8e31_a4d7_4b09_9c63_e1b8_27f4_0d5a;
    localparam logic [15:0]  PCLK_FREQ_MHZ = 16'd250;
    // Code 3 marks a 512-bit read/write bus
    localparam logic [1:0]   BUS_WIDTH_CODE = 2'd3;
    // Code 1 marks an AXI-style MMIO interface
    localparam logic [3:0]   IF_KIND_CODE = 4'd1;
    // Feature type written into the device feature header
    localparam logic [3:0]   DFH_TYPE_AFU = 4'h1;

    // Each read map group covers sixteen indices from its base
    localparam csr_idx_t CSR_IDX_HDR_BASE   = 12'h000;
    localparam csr_idx_t CSR_IDX_STATUS     = 12'h010;
    localparam csr_idx_t CSR_IDX_WR64_DATA  = 12'h020;
    localparam csr_idx_t CSR_IDX_WR64_INFO  = 12'h030;
    localparam csr_idx_t CSR_IDX_WR512_DATA = 12'h040;
    localparam csr_idx_t CSR_IDX_WR512_INFO = 12'h050;

endpackage

`default_nettype wire
